//--- common/axi_lite_cdc_pkg.sv
package axi_lite_cdc_pkg;

  // Bus widths, one word each
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Field types
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] word_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [2:0]           prot_t;

  // AXI response code
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Write address channel
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } aw_chan_t;

  // Write data channel
  typedef struct packed {
    word_t data;
    strb_t strb;
  } w_chan_t;

  // Write response channel
  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  // Read address channel
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } ar_chan_t;

  // Read data channel
  typedef struct packed {
    word_t data;
    resp_t resp;
  } r_chan_t;

  // Signals driven by the manager
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_req_t;

  // Signals driven by the subordinate
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axil_rsp_t;

endpackage

//--- cdc_fifo/cdc_fifo_src.sv
`timescale 1ns/1ps

module cdc_fifo_src #(
  parameter type         data_t   = logic,
  parameter int unsigned LogDepth = 2
) (
  input  logic                     src_clk_i,
  input  logic                     arst_n_i,
  // Push side, source clock domain
  input  data_t                    data_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  // Crossing towards the read half
  output data_t [2**LogDepth-1:0]  async_data_o,
  output logic  [LogDepth:0]       async_wptr_o,
  input  logic  [LogDepth:0]       async_rptr_i
);

  localparam int unsigned Depth = 2**LogDepth;

  // Full when the top two gray bits differ and the rest match
  localparam logic [LogDepth:0] FullMask = (LogDepth+1)'(3) << (LogDepth - 1);

  data_t [Depth-1:0] mem_q;

  logic [LogDepth:0] wptr_bin_q;
  logic [LogDepth:0] wptr_bin_d;
  logic [LogDepth:0] wptr_gray_q;
  logic [LogDepth:0] wptr_gray_d;
  logic [LogDepth:0] rptr_sync1_q;
  logic [LogDepth:0] rptr_sync2_q;
  logic              push;

  // Handshake on the push side
  assign ready_o = (wptr_gray_q != (rptr_sync2_q ^ FullMask));
  assign push    = valid_i & ready_o;

  // Next pointer, binary and gray
  always_comb begin
    wptr_bin_d = wptr_bin_q;
    if (push) begin
      wptr_bin_d = wptr_bin_q + 1'b1;
    end
    wptr_gray_d = wptr_bin_d ^ (wptr_bin_d >> 1);
  end

  always_ff @(posedge src_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_bin_q  <= '0;
      wptr_gray_q <= '0;
    end else begin
      wptr_bin_q  <= wptr_bin_d;
      wptr_gray_q <= wptr_gray_d;
    end
  end

  // Storage, read directly by the other clock domain
  always_ff @(posedge src_clk_i) begin
    if (push) begin
      mem_q[wptr_bin_q[LogDepth-1:0]] <= data_i;
    end
  end

  // Two-stage synchronizer for the remote read pointer
  always_ff @(posedge src_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_sync1_q <= '0;
      rptr_sync2_q <= '0;
    end else begin
      rptr_sync1_q <= async_rptr_i;
      rptr_sync2_q <= rptr_sync1_q;
    end
  end

  // Only registered gray values leave this domain
  assign async_data_o = mem_q;
  assign async_wptr_o = wptr_gray_q;

endmodule

//--- cdc_fifo/cdc_fifo_dst.sv
`timescale 1ns/1ps

module cdc_fifo_dst #(
  parameter type         data_t   = logic,
  parameter int unsigned LogDepth = 2
) (
  input  logic                     dst_clk_i,
  input  logic                     arst_n_i,
  // Pop side, destination clock domain
  output data_t                    data_o,
  output logic                     valid_o,
  input  logic                     ready_i,
  // Crossing from the write half
  input  data_t [2**LogDepth-1:0]  async_data_i,
  input  logic  [LogDepth:0]       async_wptr_i,
  output logic  [LogDepth:0]       async_rptr_o
);

  logic [LogDepth:0] rptr_bin_q;
  logic [LogDepth:0] rptr_bin_d;
  logic [LogDepth:0] rptr_gray_q;
  logic [LogDepth:0] rptr_gray_d;
  logic [LogDepth:0] wptr_sync1_q;
  logic [LogDepth:0] wptr_sync2_q;
  logic              pop;

  // Two-stage synchronizer for the remote write pointer
  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_sync1_q <= '0;
      wptr_sync2_q <= '0;
    end else begin
      wptr_sync1_q <= async_wptr_i;
      wptr_sync2_q <= wptr_sync1_q;
    end
  end

  // Not empty while the pointers differ
  assign valid_o = (rptr_gray_q != wptr_sync2_q);
  assign pop     = valid_o & ready_i;

  // The slot is stable once its write pointer has been synchronized
  assign data_o = async_data_i[rptr_bin_q[LogDepth-1:0]];

  // Next pointer, binary and gray
  always_comb begin
    rptr_bin_d = rptr_bin_q;
    if (pop) begin
      rptr_bin_d = rptr_bin_q + 1'b1;
    end
    rptr_gray_d = rptr_bin_d ^ (rptr_bin_d >> 1);
  end

  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_bin_q  <= '0;
      rptr_gray_q <= '0;
    end else begin
      rptr_bin_q  <= rptr_bin_d;
      rptr_gray_q <= rptr_gray_d;
    end
  end

  // Freed slots are reported back in gray code
  assign async_rptr_o = rptr_gray_q;

endmodule

//--- axi_lite_cdc/axi_lite_cdc_src.sv
`timescale 1ns/1ps

module axi_lite_cdc_src #(
  parameter int unsigned LogDepth = 2
) (
  input  logic                                         src_clk_i,
  input  logic                                         arst_n_i,
  // Manager port
  input  axi_lite_cdc_pkg::axil_req_t                  src_req_i,
  output axi_lite_cdc_pkg::axil_rsp_t                  src_rsp_o,
  // AW crossing
  output axi_lite_cdc_pkg::aw_chan_t [2**LogDepth-1:0] async_aw_data_o,
  output logic [LogDepth:0]                            async_aw_wptr_o,
  input  logic [LogDepth:0]                            async_aw_rptr_i,
  // W crossing
  output axi_lite_cdc_pkg::w_chan_t [2**LogDepth-1:0]  async_w_data_o,
  output logic [LogDepth:0]                            async_w_wptr_o,
  input  logic [LogDepth:0]                            async_w_rptr_i,
  // B crossing
  input  axi_lite_cdc_pkg::b_chan_t [2**LogDepth-1:0]  async_b_data_i,
  input  logic [LogDepth:0]                            async_b_wptr_i,
  output logic [LogDepth:0]                            async_b_rptr_o,
  // AR crossing
  output axi_lite_cdc_pkg::ar_chan_t [2**LogDepth-1:0] async_ar_data_o,
  output logic [LogDepth:0]                            async_ar_wptr_o,
  input  logic [LogDepth:0]                            async_ar_rptr_i,
  // R crossing
  input  axi_lite_cdc_pkg::r_chan_t [2**LogDepth-1:0]  async_r_data_i,
  input  logic [LogDepth:0]                            async_r_wptr_i,
  output logic [LogDepth:0]                            async_r_rptr_o
);

  import axi_lite_cdc_pkg::*;

  logic    aw_ready, w_ready, ar_ready;
  logic    b_valid, r_valid;
  b_chan_t b_data;
  r_chan_t r_data;

  // Request channels are pushed into the crossing
  cdc_fifo_src #(.data_t(aw_chan_t), .LogDepth(LogDepth)) i_aw_fifo (
    .src_clk_i, .arst_n_i,
    .data_i       (src_req_i.aw),
    .valid_i      (src_req_i.aw_valid),
    .ready_o      (aw_ready),
    .async_data_o (async_aw_data_o),
    .async_wptr_o (async_aw_wptr_o),
    .async_rptr_i (async_aw_rptr_i)
  );

  cdc_fifo_src #(.data_t(w_chan_t), .LogDepth(LogDepth)) i_w_fifo (
    .src_clk_i, .arst_n_i,
    .data_i       (src_req_i.w),
    .valid_i      (src_req_i.w_valid),
    .ready_o      (w_ready),
    .async_data_o (async_w_data_o),
    .async_wptr_o (async_w_wptr_o),
    .async_rptr_i (async_w_rptr_i)
  );

  cdc_fifo_src #(.data_t(ar_chan_t), .LogDepth(LogDepth)) i_ar_fifo (
    .src_clk_i, .arst_n_i,
    .data_i       (src_req_i.ar),
    .valid_i      (src_req_i.ar_valid),
    .ready_o      (ar_ready),
    .async_data_o (async_ar_data_o),
    .async_wptr_o (async_ar_wptr_o),
    .async_rptr_i (async_ar_rptr_i)
  );

  // Responses are popped back in the source clock
  cdc_fifo_dst #(.data_t(b_chan_t), .LogDepth(LogDepth)) i_b_fifo (
    .dst_clk_i    (src_clk_i),
    .arst_n_i,
    .data_o       (b_data),
    .valid_o      (b_valid),
    .ready_i      (src_req_i.b_ready),
    .async_data_i (async_b_data_i),
    .async_wptr_i (async_b_wptr_i),
    .async_rptr_o (async_b_rptr_o)
  );

  cdc_fifo_dst #(.data_t(r_chan_t), .LogDepth(LogDepth)) i_r_fifo (
    .dst_clk_i    (src_clk_i),
    .arst_n_i,
    .data_o       (r_data),
    .valid_o      (r_valid),
    .ready_i      (src_req_i.r_ready),
    .async_data_i (async_r_data_i),
    .async_wptr_i (async_r_wptr_i),
    .async_rptr_o (async_r_rptr_o)
  );

  // Gather the subordinate-side signals for the manager
  always_comb begin
    src_rsp_o.aw_ready = aw_ready;
    src_rsp_o.w_ready  = w_ready;
    src_rsp_o.b        = b_data;
    src_rsp_o.b_valid  = b_valid;
    src_rsp_o.ar_ready = ar_ready;
    src_rsp_o.r        = r_data;
    src_rsp_o.r_valid  = r_valid;
  end

endmodule

//--- axi_lite_cdc/axi_lite_cdc_dst.sv
`timescale 1ns/1ps

module axi_lite_cdc_dst #(
  parameter int unsigned LogDepth = 2
) (
  input  logic                                         dst_clk_i,
  input  logic                                         arst_n_i,
  // Subordinate port
  output axi_lite_cdc_pkg::axil_req_t                  dst_req_o,
  input  axi_lite_cdc_pkg::axil_rsp_t                  dst_rsp_i,
  // AW crossing
  input  axi_lite_cdc_pkg::aw_chan_t [2**LogDepth-1:0] async_aw_data_i,
  input  logic [LogDepth:0]                            async_aw_wptr_i,
  output logic [LogDepth:0]                            async_aw_rptr_o,
  // W crossing
  input  axi_lite_cdc_pkg::w_chan_t [2**LogDepth-1:0]  async_w_data_i,
  input  logic [LogDepth:0]                            async_w_wptr_i,
  output logic [LogDepth:0]                            async_w_rptr_o,
  // B crossing
  output axi_lite_cdc_pkg::b_chan_t [2**LogDepth-1:0]  async_b_data_o,
  output logic [LogDepth:0]                            async_b_wptr_o,
  input  logic [LogDepth:0]                            async_b_rptr_i,
  // AR crossing
  input  axi_lite_cdc_pkg::ar_chan_t [2**LogDepth-1:0] async_ar_data_i,
  input  logic [LogDepth:0]                            async_ar_wptr_i,
  output logic [LogDepth:0]                            async_ar_rptr_o,
  // R crossing
  output axi_lite_cdc_pkg::r_chan_t [2**LogDepth-1:0]  async_r_data_o,
  output logic [LogDepth:0]                            async_r_wptr_o,
  input  logic [LogDepth:0]                            async_r_rptr_i
);

  import axi_lite_cdc_pkg::*;

  aw_chan_t aw_data;
  w_chan_t  w_data;
  ar_chan_t ar_data;
  logic     aw_valid, w_valid, ar_valid;
  logic     b_ready, r_ready;

  // Requests leave the crossing in the destination clock
  cdc_fifo_dst #(.data_t(aw_chan_t), .LogDepth(LogDepth)) i_aw_fifo (
    .dst_clk_i, .arst_n_i,
    .data_o       (aw_data),
    .valid_o      (aw_valid),
    .ready_i      (dst_rsp_i.aw_ready),
    .async_data_i (async_aw_data_i),
    .async_wptr_i (async_aw_wptr_i),
    .async_rptr_o (async_aw_rptr_o)
  );

  cdc_fifo_dst #(.data_t(w_chan_t), .LogDepth(LogDepth)) i_w_fifo (
    .dst_clk_i, .arst_n_i,
    .data_o       (w_data),
    .valid_o      (w_valid),
    .ready_i      (dst_rsp_i.w_ready),
    .async_data_i (async_w_data_i),
    .async_wptr_i (async_w_wptr_i),
    .async_rptr_o (async_w_rptr_o)
  );

  cdc_fifo_dst #(.data_t(ar_chan_t), .LogDepth(LogDepth)) i_ar_fifo (
    .dst_clk_i, .arst_n_i,
    .data_o       (ar_data),
    .valid_o      (ar_valid),
    .ready_i      (dst_rsp_i.ar_ready),
    .async_data_i (async_ar_data_i),
    .async_wptr_i (async_ar_wptr_i),
    .async_rptr_o (async_ar_rptr_o)
  );

  // Responses enter the crossing here
  cdc_fifo_src #(.data_t(b_chan_t), .LogDepth(LogDepth)) i_b_fifo (
    .src_clk_i    (dst_clk_i),
    .arst_n_i,
    .data_i       (dst_rsp_i.b),
    .valid_i      (dst_rsp_i.b_valid),
    .ready_o      (b_ready),
    .async_data_o (async_b_data_o),
    .async_wptr_o (async_b_wptr_o),
    .async_rptr_i (async_b_rptr_i)
  );

  cdc_fifo_src #(.data_t(r_chan_t), .LogDepth(LogDepth)) i_r_fifo (
    .src_clk_i    (dst_clk_i),
    .arst_n_i,
    .data_i       (dst_rsp_i.r),
    .valid_i      (dst_rsp_i.r_valid),
    .ready_o      (r_ready),
    .async_data_o (async_r_data_o),
    .async_wptr_o (async_r_wptr_o),
    .async_rptr_i (async_r_rptr_i)
  );

  // Rebuild the manager-side request for the subordinate
  always_comb begin
    dst_req_o.aw       = aw_data;
    dst_req_o.aw_valid = aw_valid;
    dst_req_o.w        = w_data;
    dst_req_o.w_valid  = w_valid;
    dst_req_o.b_ready  = b_ready;
    dst_req_o.ar       = ar_data;
    dst_req_o.ar_valid = ar_valid;
    dst_req_o.r_ready  = r_ready;
  end

endmodule

//--- axi_lite_cdc/axi_lite_cdc.sv
`timescale 1ns/1ps

module axi_lite_cdc #(
  parameter int unsigned LogDepth = 2
) (
  input  logic                        src_clk_i,
  input  logic                        dst_clk_i,
  input  logic                        arst_n_i,
  // Manager side, source clock
  input  axi_lite_cdc_pkg::axil_req_t src_req_i,
  output axi_lite_cdc_pkg::axil_rsp_t src_rsp_o,
  // Subordinate side, destination clock
  output axi_lite_cdc_pkg::axil_req_t dst_req_o,
  input  axi_lite_cdc_pkg::axil_rsp_t dst_rsp_i
);

  import axi_lite_cdc_pkg::*;

  // Storage arrays seen by both domains
  aw_chan_t [2**LogDepth-1:0] async_aw_data;
  w_chan_t  [2**LogDepth-1:0] async_w_data;
  b_chan_t  [2**LogDepth-1:0] async_b_data;
  ar_chan_t [2**LogDepth-1:0] async_ar_data;
  r_chan_t  [2**LogDepth-1:0] async_r_data;

  // Gray pointers crossing between the domains
  logic [LogDepth:0] async_aw_wptr, async_aw_rptr;
  logic [LogDepth:0] async_w_wptr,  async_w_rptr;
  logic [LogDepth:0] async_b_wptr,  async_b_rptr;
  logic [LogDepth:0] async_ar_wptr, async_ar_rptr;
  logic [LogDepth:0] async_r_wptr,  async_r_rptr;

  axi_lite_cdc_src #(.LogDepth(LogDepth)) i_axi_lite_cdc_src (
    .src_clk_i, .arst_n_i, .src_req_i, .src_rsp_o,
    .async_aw_data_o (async_aw_data), .async_aw_wptr_o (async_aw_wptr),
    .async_aw_rptr_i (async_aw_rptr),
    .async_w_data_o  (async_w_data),  .async_w_wptr_o  (async_w_wptr),
    .async_w_rptr_i  (async_w_rptr),
    .async_b_data_i  (async_b_data),  .async_b_wptr_i  (async_b_wptr),
    .async_b_rptr_o  (async_b_rptr),
    .async_ar_data_o (async_ar_data), .async_ar_wptr_o (async_ar_wptr),
    .async_ar_rptr_i (async_ar_rptr),
    .async_r_data_i  (async_r_data),  .async_r_wptr_i  (async_r_wptr),
    .async_r_rptr_o  (async_r_rptr)
  );

  axi_lite_cdc_dst #(.LogDepth(LogDepth)) i_axi_lite_cdc_dst (
    .dst_clk_i, .arst_n_i, .dst_req_o, .dst_rsp_i,
    .async_aw_data_i (async_aw_data), .async_aw_wptr_i (async_aw_wptr),
    .async_aw_rptr_o (async_aw_rptr),
    .async_w_data_i  (async_w_data),  .async_w_wptr_i  (async_w_wptr),
    .async_w_rptr_o  (async_w_rptr),
    .async_b_data_o  (async_b_data),  .async_b_wptr_o  (async_b_wptr),
    .async_b_rptr_i  (async_b_rptr),
    .async_ar_data_i (async_ar_data), .async_ar_wptr_i (async_ar_wptr),
    .async_ar_rptr_o (async_ar_rptr),
    .async_r_data_o  (async_r_data),  .async_r_wptr_o  (async_r_wptr),
    .async_r_rptr_i  (async_r_rptr)
  );

endmodule

//--- verification/tb_axi_lite_mem.sv
`timescale 1ns/1ps

module tb_axi_lite_mem #(
  parameter int unsigned Words = 64
) (
  input  logic                        dst_clk_i,
  input  logic                        arst_n_i,
  input  axi_lite_cdc_pkg::axil_req_t req_i,
  output axi_lite_cdc_pkg::axil_rsp_t rsp_o
);

  import axi_lite_cdc_pkg::*;

  localparam int unsigned IdxWidth = $clog2(Words);
  localparam logic [16:0] Seed     = 17'd66564;

  word_t       mem_q [Words];
  logic [16:0] lfsr_q;
  logic [16:0] lfsr_one;
  logic [16:0] lfsr_two;
  logic        req_stall_q;
  logic        rsp_stall_q;
  b_chan_t     b_q;
  logic        b_pend_q;
  logic        b_valid_q;
  r_chan_t     r_q;
  logic        r_pend_q;
  logic        r_valid_q;
  logic        wr_take;
  logic        rd_take;
  logic        wr_hit;
  logic        rd_hit;

  // 17-bit Fibonacci LFSR with taps 17 and 14
  function automatic logic [16:0] lfsr_next(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};
  endfunction

  // Two bits per cycle, one for request stalls and one for response stalls
  assign lfsr_one = lfsr_next(lfsr_q);
  assign lfsr_two = lfsr_next(lfsr_one);

  // Address and data are taken together, one response outstanding per direction
  assign wr_take = req_i.aw_valid & req_i.w_valid & ~b_pend_q & ~b_valid_q & ~req_stall_q;
  assign rd_take = req_i.ar_valid & ~r_pend_q & ~r_valid_q & ~req_stall_q;
  assign wr_hit  = (req_i.aw.addr >> 2) < Words;
  assign rd_hit  = (req_i.ar.addr >> 2) < Words;

  always_comb begin
    rsp_o          = '0;
    rsp_o.aw_ready = wr_take;
    rsp_o.w_ready  = wr_take;
    rsp_o.b        = b_q;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.ar_ready = rd_take;
    rsp_o.r        = r_q;
    rsp_o.r_valid  = r_valid_q;
  end

  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // Fill pattern is the byte address of each word
      for (int i = 0; i < Words; i++) begin
        mem_q[i] <= 32'hC0DE_0000 + i * 4;
      end
      lfsr_q      <= Seed;
      req_stall_q <= 1'b0;
      rsp_stall_q <= 1'b0;
      b_q         <= '0;
      b_pend_q    <= 1'b0;
      b_valid_q   <= 1'b0;
      r_q         <= '0;
      r_pend_q    <= 1'b0;
      r_valid_q   <= 1'b0;
    end else begin
      lfsr_q      <= lfsr_two;
      req_stall_q <= lfsr_one[0];
      rsp_stall_q <= lfsr_two[0];
      if (wr_take) begin
        b_pend_q <= 1'b1;
        b_q.resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        for (int b = 0; b < StrbWidth; b++) begin
          if (wr_hit && req_i.w.strb[b]) begin
            mem_q[req_i.aw.addr[2 +: IdxWidth]][8*b +: 8] <= req_i.w.data[8*b +: 8];
          end
        end
      end
      if (rd_take) begin
        r_pend_q <= 1'b1;
        r_q.resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        r_q.data <= rd_hit ? mem_q[req_i.ar.addr[2 +: IdxWidth]] : '0;
      end
      // A response is raised late on stall cycles and held until accepted
      if (b_pend_q && !rsp_stall_q) begin
        b_pend_q  <= 1'b0;
        b_valid_q <= 1'b1;
      end
      if (b_valid_q && req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (r_pend_q && !rsp_stall_q) begin
        r_pend_q  <= 1'b0;
        r_valid_q <= 1'b1;
      end
      if (r_valid_q && req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

endmodule

//--- verification/tb_axi_lite_cdc.sv
`timescale 1ns/1ps

module tb_axi_lite_cdc;

  import axi_lite_cdc_pkg::*;

  localparam int unsigned LogDepth  = 2;
  localparam int unsigned Depth     = 2**LogDepth;
  localparam int unsigned MemWords  = 64;
  localparam int unsigned Timeout   = 300;
  localparam int unsigned NumOps    = 10;
  localparam int unsigned NumStream = 12;

  // One row of the directed table
  typedef struct packed {
    bit    is_write;
    addr_t addr;
    word_t wdata;
    strb_t strb;
    word_t exp_rdata;
    resp_t exp_resp;
  } op_t;

  logic      src_clk;
  logic      dst_clk;
  logic      arst_n;
  axil_req_t src_req;
  axil_rsp_t src_rsp;
  axil_req_t dst_req;
  axil_rsp_t dst_rsp;

  op_t      op_table [NumOps];
  word_t    ref_mem [MemWords];
  resp_t    b_exp_q [$];
  word_t    r_data_exp_q [$];
  resp_t    r_resp_exp_q [$];
  aw_chan_t aw_exp_q [$];
  ar_chan_t ar_exp_q [$];
  int       check_count;
  int       mismatch_count;
  int       failure_count;

  axi_lite_cdc #(.LogDepth(LogDepth)) u_axi_lite_cdc (
    .src_clk_i (src_clk),
    .dst_clk_i (dst_clk),
    .arst_n_i  (arst_n),
    .src_req_i (src_req),
    .src_rsp_o (src_rsp),
    .dst_req_o (dst_req),
    .dst_rsp_i (dst_rsp)
  );

  tb_axi_lite_mem #(.Words(MemWords)) u_mem (
    .dst_clk_i (dst_clk),
    .arst_n_i  (arst_n),
    .req_i     (dst_req),
    .rsp_o     (dst_rsp)
  );

  initial begin
    src_clk = 1'b0;
    forever #2 src_clk = ~src_clk;
  end

  // Unrelated destination clock
  initial begin
    dst_clk = 1'b0;
    forever #3 dst_clk = ~dst_clk;
  end

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic report_and_finish();
    $display("Checks: %0d, mismatches: %0d, other failures: %0d",
             check_count, mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic abort_on_hang(input string what);
    failure_count++;
    $display("Timeout at %0t: %s", $time, what);
    report_and_finish();
  endtask

  // Inputs change just after the rising source edge
  task automatic next_cycle();
    @(posedge src_clk);
    #1;
  endtask

  // Reference memory, same fill rule and byte merge as an AXI-Lite RAM
  task automatic ref_write(input addr_t addr, input word_t data, input strb_t strb,
                           output resp_t resp);
    resp = RESP_SLVERR;
    if ((addr >> 2) < MemWords) begin
      resp = RESP_OKAY;
      for (int b = 0; b < StrbWidth; b++) begin
        if (strb[b]) begin
          ref_mem[addr[7:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic ref_read(input addr_t addr, output word_t data, output resp_t resp);
    data = '0;
    resp = RESP_SLVERR;
    if ((addr >> 2) < MemWords) begin
      data = ref_mem[addr[7:2]];
      resp = RESP_OKAY;
    end
  endtask

  task automatic send_write(input addr_t addr, input word_t data, input strb_t strb);
    int   cycles;
    logic aw_hit;
    logic w_hit;
    cycles           = 0;
    src_req.aw.addr  = addr;
    // Protection bits follow the word address
    src_req.aw.prot  = addr[4:2];
    src_req.w.data   = data;
    src_req.w.strb   = strb;
    aw_exp_q.push_back(src_req.aw);
    src_req.aw_valid = 1'b1;
    src_req.w_valid  = 1'b1;
    while (src_req.aw_valid || src_req.w_valid) begin
      if (cycles == Timeout) begin
        if (src_req.aw_valid) begin
          abort_on_hang("AW channel hung, write address never accepted");
        end else begin
          abort_on_hang("W channel hung, write data never accepted");
        end
      end
      aw_hit = src_req.aw_valid & src_rsp.aw_ready;
      w_hit  = src_req.w_valid & src_rsp.w_ready;
      next_cycle();
      if (aw_hit) begin
        src_req.aw_valid = 1'b0;
      end
      if (w_hit) begin
        src_req.w_valid = 1'b0;
      end
      cycles++;
    end
  endtask

  task automatic send_read(input addr_t addr);
    int cycles;
    cycles           = 0;
    src_req.ar.addr  = addr;
    src_req.ar.prot  = addr[4:2];
    ar_exp_q.push_back(src_req.ar);
    src_req.ar_valid = 1'b1;
    while (!src_rsp.ar_ready) begin
      if (cycles == Timeout) begin
        abort_on_hang("AR channel hung, read address never accepted");
      end
      next_cycle();
      cycles++;
    end
    next_cycle();
    src_req.ar_valid = 1'b0;
  endtask

  task automatic receive_b(output resp_t resp);
    int cycles;
    cycles          = 0;
    src_req.b_ready = 1'b1;
    while (!src_rsp.b_valid) begin
      if (cycles == Timeout) begin
        abort_on_hang("B channel hung, no write response arrived");
      end
      next_cycle();
      cycles++;
    end
    resp = src_rsp.b.resp;
    next_cycle();
    src_req.b_ready = 1'b0;
  endtask

  task automatic receive_r(output word_t data, output resp_t resp);
    int cycles;
    cycles          = 0;
    src_req.r_ready = 1'b1;
    while (!src_rsp.r_valid) begin
      if (cycles == Timeout) begin
        abort_on_hang("R channel hung, no read data arrived");
      end
      next_cycle();
      cycles++;
    end
    data = src_rsp.r.data;
    resp = src_rsp.r.resp;
    next_cycle();
    src_req.r_ready = 1'b0;
  endtask

  // Requests must reach the subordinate intact and in order
  always @(negedge dst_clk) begin
    aw_chan_t aw_exp;
    ar_chan_t ar_exp;
    if (dst_req.aw_valid && dst_rsp.aw_ready) begin
      if (aw_exp_q.size() == 0) begin
        failure_count++;
        $display("Write address at %0t reached the subordinate with none issued", $time);
      end else begin
        aw_exp = aw_exp_q.pop_front();
        check_equal("dst_req_o.aw.addr", dst_req.aw.addr, aw_exp.addr);
        check_equal("dst_req_o.aw.prot", dst_req.aw.prot, aw_exp.prot);
      end
    end
    if (dst_req.ar_valid && dst_rsp.ar_ready) begin
      if (ar_exp_q.size() == 0) begin
        failure_count++;
        $display("Read address at %0t reached the subordinate with none issued", $time);
      end else begin
        ar_exp = ar_exp_q.pop_front();
        check_equal("dst_req_o.ar.addr", dst_req.ar.addr, ar_exp.addr);
        check_equal("dst_req_o.ar.prot", dst_req.ar.prot, ar_exp.prot);
      end
    end
  end

  task automatic set_op(input int idx, input bit is_write, input addr_t addr,
                        input word_t wdata, input strb_t strb);
    op_table[idx].is_write  = is_write;
    op_table[idx].addr      = addr;
    op_table[idx].wdata     = wdata;
    op_table[idx].strb      = strb;
    op_table[idx].exp_rdata = '0;
    op_table[idx].exp_resp  = RESP_OKAY;
  endtask

  task automatic load_table();
    set_op(0, 1'b1, 32'h0000_0010, 32'h1234_5678, 4'b1111);
    set_op(1, 1'b0, 32'h0000_0010, '0, '0);
    set_op(2, 1'b1, 32'h0000_0014, 32'hAABB_CCDD, 4'b0101);
    set_op(3, 1'b0, 32'h0000_0014, '0, '0);
    set_op(4, 1'b1, 32'h0000_0014, 32'h1122_3344, 4'b1000);
    set_op(5, 1'b0, 32'h0000_0014, '0, '0);
    // Word 64 and beyond answer with SLVERR
    set_op(6, 1'b1, 32'h0000_0100, 32'hDEAD_BEEF, 4'b1111);
    set_op(7, 1'b0, 32'h0000_0100, '0, '0);
    set_op(8, 1'b0, 32'h0000_00FC, '0, '0);
    set_op(9, 1'b0, 32'hFFFF_FFF0, '0, '0);
  endtask

  task automatic stream_writes();
    addr_t addr;
    word_t data;
    strb_t strb;
    resp_t resp;
    for (int i = 0; i < NumStream; i++) begin
      addr = (i % 5 == 4) ? 32'h0000_1000 + i * 4 : 32'h0000_0080 + (i % 8) * 4;
      data = 32'h5A5A_5A5A ^ (i * 32'h0101_0101);
      strb = (i % 3 == 1) ? 4'b0110 : 4'b1111;
      ref_write(addr, data, strb, resp);
      b_exp_q.push_back(resp);
      send_write(addr, data, strb);
    end
  endtask

  // Reads stay below word 32 so they never overlap the stream writes
  task automatic stream_reads();
    addr_t addr;
    word_t data;
    resp_t resp;
    for (int i = 0; i < NumStream; i++) begin
      addr = (i % 4 == 3) ? 32'h0001_0000 + i * 4 : ((i * 7) % 32) * 4;
      ref_read(addr, data, resp);
      r_data_exp_q.push_back(data);
      r_resp_exp_q.push_back(resp);
      send_read(addr);
    end
  endtask

  task automatic collect_b(input int count);
    resp_t resp;
    for (int i = 0; i < count; i++) begin
      receive_b(resp);
      if (b_exp_q.size() == 0) begin
        failure_count++;
        $display("Write response at %0t with no write outstanding", $time);
      end else begin
        check_equal("src_rsp_o.b.resp", resp, b_exp_q.pop_front());
      end
    end
  endtask

  task automatic collect_r(input int count);
    word_t data;
    resp_t resp;
    for (int i = 0; i < count; i++) begin
      receive_r(data, resp);
      if (r_data_exp_q.size() == 0) begin
        failure_count++;
        $display("Read data at %0t with no read outstanding", $time);
      end else begin
        check_equal("src_rsp_o.r.data", data, r_data_exp_q.pop_front());
        check_equal("src_rsp_o.r.resp", resp, r_resp_exp_q.pop_front());
      end
    end
  endtask

  initial begin
    word_t rdata;
    resp_t resp;
    addr_t addr;
    word_t wdata;
    int    issued;
    bit    dropped;

    src_req        = '0;
    arst_n         = 1'b0;
    check_count    = 0;
    mismatch_count = 0;
    failure_count  = 0;
    for (int i = 0; i < MemWords; i++) begin
      ref_mem[i] = 32'hC0DE_0000 + i * 4;
    end

    // Expected columns of the table come from the reference memory
    load_table();
    for (int i = 0; i < NumOps; i++) begin
      if (op_table[i].is_write) begin
        ref_write(op_table[i].addr, op_table[i].wdata, op_table[i].strb, resp);
      end else begin
        ref_read(op_table[i].addr, rdata, resp);
        op_table[i].exp_rdata = rdata;
      end
      op_table[i].exp_resp = resp;
    end

    repeat (2) @(posedge src_clk);
    #1;
    arst_n = 1'b1;
    next_cycle();

    // Idle handshake levels after reset
    check_equal("src_rsp_o.b_valid", src_rsp.b_valid, 1'b0);
    check_equal("src_rsp_o.r_valid", src_rsp.r_valid, 1'b0);
    check_equal("src_rsp_o.aw_ready", src_rsp.aw_ready, 1'b1);
    check_equal("src_rsp_o.w_ready", src_rsp.w_ready, 1'b1);
    check_equal("src_rsp_o.ar_ready", src_rsp.ar_ready, 1'b1);

    for (int i = 0; i < NumOps; i++) begin
      if (op_table[i].is_write) begin
        send_write(op_table[i].addr, op_table[i].wdata, op_table[i].strb);
        receive_b(resp);
        check_equal("src_rsp_o.b.resp", resp, op_table[i].exp_resp);
      end else begin
        send_read(op_table[i].addr);
        receive_r(rdata, resp);
        check_equal("src_rsp_o.r.data", rdata, op_table[i].exp_rdata);
        check_equal("src_rsp_o.r.resp", resp, op_table[i].exp_resp);
      end
    end

    // Hold B back until the write FIFOs fill and aw_ready drops
    issued  = 0;
    dropped = 1'b0;
    while (!dropped && issued < 5 * Depth) begin
      addr  = (issued % 3 == 2) ? 32'h0000_0400 : 32'h0000_0080 + issued * 4;
      wdata = 32'hB000_0000 | issued;
      ref_write(addr, wdata, 4'b1111, resp);
      b_exp_q.push_back(resp);
      send_write(addr, wdata, 4'b1111);
      issued++;
      dropped = !src_rsp.aw_ready;
    end
    if (!dropped) begin
      failure_count++;
      $display("aw_ready never dropped while write responses were held back");
    end
    collect_b(issued);

    // Overlapping reads and writes against random destination stalls
    fork
      stream_writes();
      stream_reads();
      collect_b(NumStream);
      collect_r(NumStream);
    join

    // Nothing may be left over or repeated
    repeat (20) next_cycle();
    check_equal("src_rsp_o.b_valid", src_rsp.b_valid, 1'b0);
    check_equal("src_rsp_o.r_valid", src_rsp.r_valid, 1'b0);
    check_equal("pending write responses", b_exp_q.size(), 0);
    check_equal("pending read responses", r_data_exp_q.size(), 0);

    report_and_finish();
  end

endmodule

//--- sim.f
common/axi_lite_cdc_pkg.sv
cdc_fifo/cdc_fifo_src.sv
cdc_fifo/cdc_fifo_dst.sv
axi_lite_cdc/axi_lite_cdc_src.sv
axi_lite_cdc/axi_lite_cdc_dst.sv
axi_lite_cdc/axi_lite_cdc.sv
verification/tb_axi_lite_mem.sv
verification/tb_axi_lite_cdc.sv
